// File: rtl/exe_pkg.sv
`default_nettype none

package exe_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef enum logic [4:0] {
        OP_ADD = 5'd0, OP_SUB, OP_SLT, OP_SLTU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLL, OP_SRL, OP_SRA, OP_LUI,
        OP_MUL, OP_MULH, OP_MULHU,
        OP_DIV, OP_MOD, OP_DIVU, OP_MODU,
        OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU,
        OP_ST_B, OP_ST_H, OP_ST_W
    } exe_op_e;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    // a zero divisor gives an all-ones quotient and leaves the dividend as remainder.
    localparam logic [XLEN-1:0] DIV_ZERO_Q = '1;

    function automatic logic op_is_div(exe_op_e op);
        return op inside {OP_DIV, OP_MOD, OP_DIVU, OP_MODU};
    endfunction

    function automatic logic op_is_load(exe_op_e op);
        return op inside {OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU};
    endfunction

    function automatic logic op_is_store(exe_op_e op);
        return op inside {OP_ST_B, OP_ST_H, OP_ST_W};
    endfunction

endpackage

`default_nettype wire

// File: rtl/exe_ifs.sv
`timescale 1ns/1ps
`default_nettype none

interface div_if;
    logic                       start;
    logic                       cancel;
    logic                       is_signed;
    logic [exe_pkg::XLEN-1:0]   dividend;
    logic [exe_pkg::XLEN-1:0]   divisor;
    logic                       done;      // stays high with the result until the next start.
    logic [exe_pkg::XLEN-1:0]   quotient;
    logic [exe_pkg::XLEN-1:0]   remainder;

    modport ctrl (output start, cancel, is_signed, dividend, divisor,
                  input  done, quotient, remainder);
    modport unit (input  start, cancel, is_signed, dividend, divisor,
                  output done, quotient, remainder);
endinterface

interface mem_if;
    logic                       go;
    exe_pkg::exe_op_e           op;
    logic [exe_pkg::XLEN-1:0]   addr;
    logic [exe_pkg::XLEN-1:0]   st_value;
    logic                       accepted;  // req and addr_ok in the same cycle.
    logic                       ale;
    logic                       pending;

    modport ctrl (output go, op, addr, st_value,
                  input  accepted, ale, pending);
    modport unit (input  go, op, addr, st_value,
                  output accepted, ale, pending);
endinterface

`default_nettype wire

// File: rtl/exe_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exe_alu (
    input  exe_pkg::exe_op_e            op,
    input  logic [exe_pkg::XLEN-1:0]    src1,
    input  logic [exe_pkg::XLEN-1:0]    src2,
    output logic [exe_pkg::XLEN-1:0]    result
);

    localparam int W = exe_pkg::XLEN;

    logic                   mul_signed;
    logic signed [W:0]      mul_a;
    logic signed [W:0]      mul_b;
    logic signed [2*W+1:0]  prod;
    logic [W-1:0]           sum;
    logic [W-1:0]           diff;
    logic [4:0]             shamt;

    // one extra bit per operand lets a single signed multiplier serve both kinds.
    assign mul_signed = (op != exe_pkg::OP_MULHU);
    assign mul_a      = {mul_signed & src1[W-1], src1};
    assign mul_b      = {mul_signed & src2[W-1], src2};
    assign prod       = mul_a * mul_b;

    assign sum   = src1 + src2;
    assign diff  = src1 - src2;
    assign shamt = src2[4:0];

    always_comb begin
        case (op)
            exe_pkg::OP_SUB:   result = diff;
            exe_pkg::OP_SLT:   result = {{(W-1){1'b0}}, $signed(src1) < $signed(src2)};
            exe_pkg::OP_SLTU:  result = {{(W-1){1'b0}}, src1 < src2};
            exe_pkg::OP_AND:   result = src1 & src2;
            exe_pkg::OP_OR:    result = src1 | src2;
            exe_pkg::OP_XOR:   result = src1 ^ src2;
            exe_pkg::OP_NOR:   result = ~(src1 | src2);
            exe_pkg::OP_SLL:   result = src1 << shamt;
            exe_pkg::OP_SRL:   result = src1 >> shamt;
            exe_pkg::OP_SRA:   result = $unsigned($signed(src1) >>> shamt);
            exe_pkg::OP_LUI:   result = src2;   // decode has already placed the upper bits.
            exe_pkg::OP_MUL:   result = prod[W-1:0];
            exe_pkg::OP_MULH,
            exe_pkg::OP_MULHU: result = prod[2*W-1:W];
            default:           result = sum;    // add, and the address of loads and stores.
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/exe_div.sv
`timescale 1ns/1ps
`default_nettype none

module exe_div #(
    parameter int DIV_BITS_PER_CYCLE = 2
) (
    input  logic    clk,
    input  logic    reset,
    div_if.unit     div
);

    localparam int W     = exe_pkg::XLEN;
    localparam int STEPS = W / DIV_BITS_PER_CYCLE;
    localparam int CW    = $clog2(STEPS) + 1;

    exe_pkg::div_state_e state;
    logic [CW-1:0]  cnt;
    logic [W:0]     rem_r;
    logic [W-1:0]   quo_r;
    logic [W-1:0]   dvs_r;
    logic           q_neg_r;
    logic           r_neg_r;
    logic           dz_r;
    logic           dd_neg;
    logic           dv_neg;
    logic [W-1:0]   dd_mag;
    logic [W-1:0]   dv_mag;
    logic [W-1:0]   dvs_cur;
    logic [W:0]     rem_nx;
    logic [W-1:0]   quo_nx;

    assign dd_neg = div.is_signed && div.dividend[W-1];
    assign dv_neg = div.is_signed && div.divisor[W-1];
    assign dd_mag = dd_neg ? -div.dividend : div.dividend;
    assign dv_mag = dv_neg ? -div.divisor  : div.divisor;
    assign dvs_cur = div.start ? dv_mag : dvs_r;

    // the first step already runs in the start cycle, straight from the operands.
    always_comb begin
        rem_nx = div.start ? '0 : rem_r;
        quo_nx = div.start ? dd_mag : quo_r;
        for (int i = 0; i < DIV_BITS_PER_CYCLE; i++) begin
            rem_nx = {rem_nx[W-1:0], quo_nx[W-1]};
            quo_nx = {quo_nx[W-2:0], 1'b0};
            if (rem_nx >= {1'b0, dvs_cur}) begin
                rem_nx    = rem_nx - {1'b0, dvs_cur};
                quo_nx[0] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= exe_pkg::DIV_IDLE;
            cnt   <= '0;
        end else if (div.cancel) begin
            state <= exe_pkg::DIV_IDLE;
        end else if (div.start) begin
            state <= exe_pkg::DIV_RUN;
            cnt   <= CW'(STEPS - 1);
        end else if (state == exe_pkg::DIV_RUN) begin
            if (cnt == CW'(1))
                state <= exe_pkg::DIV_DONE;
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (div.start || state == exe_pkg::DIV_RUN) begin
            rem_r <= rem_nx;
            quo_r <= quo_nx;
        end
        if (div.start) begin
            dvs_r   <= dv_mag;
            q_neg_r <= dd_neg ^ dv_neg;
            r_neg_r <= dd_neg;
            dz_r    <= (div.divisor == '0);
        end
    end

    // most-negative by -1 needs no special case. the magnitude 2^31 with a positive
    // sign reads back as the dividend itself, and the remainder comes out as 0.
    // a zero divisor leaves the dividend magnitude in the remainder, so only the
    // quotient is overridden.
    assign div.done      = (state == exe_pkg::DIV_DONE);
    assign div.quotient  = dz_r    ? exe_pkg::DIV_ZERO_Q
                         : q_neg_r ? -quo_r : quo_r;
    assign div.remainder = r_neg_r ? -rem_r[W-1:0] : rem_r[W-1:0];

endmodule

`default_nettype wire

// File: rtl/exe_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module exe_lsu (
    input  logic                        clk,
    input  logic                        reset,
    mem_if.unit                         mem,
    output logic                        data_sram_req,
    output logic                        data_sram_wr,
    output logic [1:0]                  data_sram_size,
    output logic [3:0]                  data_sram_wstrb,
    output logic [exe_pkg::XLEN-1:0]    data_sram_addr,
    output logic [exe_pkg::XLEN-1:0]    data_sram_wdata,
    input  logic                        data_sram_addr_ok,
    input  logic                        data_sram_data_ok
);

    logic       is_half;
    logic       is_word;
    logic       pending_r;
    logic [1:0] offset;

    assign offset  = mem.addr[1:0];
    assign is_half = mem.op inside {exe_pkg::OP_LD_H, exe_pkg::OP_LD_HU, exe_pkg::OP_ST_H};
    assign is_word = mem.op inside {exe_pkg::OP_LD_W, exe_pkg::OP_ST_W};

    assign mem.ale = (is_half && offset[0]) || (is_word && (offset != 2'b00));

    always_comb begin
        case (mem.op)
            exe_pkg::OP_ST_B: begin
                data_sram_wdata = {4{mem.st_value[7:0]}};
                data_sram_wstrb = 4'b0001 << offset;
            end
            exe_pkg::OP_ST_H: begin
                data_sram_wdata = {2{mem.st_value[15:0]}};
                data_sram_wstrb = 4'b0011 << offset;
            end
            exe_pkg::OP_ST_W: begin
                data_sram_wdata = mem.st_value;
                data_sram_wstrb = 4'b1111;
            end
            default: begin
                data_sram_wdata = mem.st_value;
                data_sram_wstrb = 4'b0000;  // loads write no byte.
            end
        endcase
    end

    assign data_sram_size = is_word ? 2'd2 : is_half ? 2'd1 : 2'd0;
    assign data_sram_req  = mem.go && !mem.ale;
    assign data_sram_wr   = exe_pkg::op_is_store(mem.op);
    assign data_sram_addr = mem.addr;

    assign mem.accepted = data_sram_req && data_sram_addr_ok;

    // a new acceptance wins over a data_ok that closes the previous access.
    always_ff @(posedge clk) begin
        if (reset)
            pending_r <= 1'b0;
        else if (mem.accepted)
            pending_r <= 1'b1;
        else if (data_sram_data_ok)
            pending_r <= 1'b0;
    end

    assign mem.pending = pending_r;

endmodule

`default_nettype wire

// File: rtl/exe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module exe_ctrl (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_valid,
    output logic                        in_allowin,
    input  exe_pkg::exe_op_e            in_op,
    input  logic [exe_pkg::XLEN-1:0]    in_pc,
    input  logic [exe_pkg::XLEN-1:0]    in_rj,
    input  logic [exe_pkg::XLEN-1:0]    in_rkd,
    input  logic [exe_pkg::XLEN-1:0]    in_imm,
    input  logic                        in_src1_is_pc,
    input  logic                        in_src2_is_imm,
    input  logic [exe_pkg::REG_AW-1:0]  in_dest,
    input  logic                        in_gr_we,
    input  logic                        out_allowin,
    output logic                        out_valid,
    output logic [exe_pkg::XLEN-1:0]    out_pc,
    output logic [exe_pkg::XLEN-1:0]    out_result,
    output logic [exe_pkg::REG_AW-1:0]  out_dest,
    output logic                        out_gr_we,
    output logic                        out_is_load,
    output logic                        out_ale,
    output logic                        fwd_valid,
    output logic                        fwd_blocked,
    output logic [exe_pkg::REG_AW-1:0]  fwd_dest,
    output logic [exe_pkg::XLEN-1:0]    fwd_result,
    input  logic                        flush,
    output exe_pkg::exe_op_e            alu_op,
    output logic [exe_pkg::XLEN-1:0]    alu_src1,
    output logic [exe_pkg::XLEN-1:0]    alu_src2,
    input  logic [exe_pkg::XLEN-1:0]    alu_result,
    div_if.ctrl                         div,
    mem_if.ctrl                         mem
);

    logic                       valid_r;
    logic                       first_r;
    exe_pkg::exe_op_e           op_r;
    logic [exe_pkg::XLEN-1:0]   pc_r;
    logic [exe_pkg::XLEN-1:0]   rj_r;
    logic [exe_pkg::XLEN-1:0]   rkd_r;
    logic [exe_pkg::XLEN-1:0]   imm_r;
    logic                       src1_is_pc_r;
    logic                       src2_is_imm_r;
    logic [exe_pkg::REG_AW-1:0] dest_r;
    logic                       gr_we_r;
    logic                       is_div;
    logic                       is_load;
    logic                       is_mem;
    logic                       ready_go;

    assign is_div  = exe_pkg::op_is_div(op_r);
    assign is_load = exe_pkg::op_is_load(op_r);
    assign is_mem  = is_load || exe_pkg::op_is_store(op_r);

    // done from the previous divide is still up in the first cycle, so it is masked there.
    always_comb begin
        if (is_div)
            ready_go = div.done && !first_r;
        else if (is_mem)
            ready_go = mem.ale || mem.accepted;
        else
            ready_go = 1'b1;
    end

    assign in_allowin = !valid_r || (ready_go && out_allowin);
    assign out_valid  = valid_r && ready_go && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
            first_r <= 1'b0;
        end else begin
            if (flush)
                valid_r <= 1'b0;
            else if (in_allowin)
                valid_r <= in_valid;
            first_r <= in_valid && in_allowin && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            op_r          <= in_op;
            pc_r          <= in_pc;
            rj_r          <= in_rj;
            rkd_r         <= in_rkd;
            imm_r         <= in_imm;
            src1_is_pc_r  <= in_src1_is_pc;
            src2_is_imm_r <= in_src2_is_imm;
            dest_r        <= in_dest;
            gr_we_r       <= in_gr_we;
        end
    end

    assign alu_op   = op_r;
    assign alu_src1 = src1_is_pc_r  ? pc_r  : rj_r;
    assign alu_src2 = src2_is_imm_r ? imm_r : rkd_r;

    assign div.start     = valid_r && first_r && is_div && !flush;
    assign div.cancel    = flush;
    assign div.is_signed = (op_r == exe_pkg::OP_DIV) || (op_r == exe_pkg::OP_MOD);
    assign div.dividend  = alu_src1;
    assign div.divisor   = alu_src2;

    assign mem.go       = valid_r && is_mem && out_allowin && !flush;
    assign mem.op       = op_r;
    assign mem.addr     = alu_result;   // the ALU adds base and offset for memory ops.
    assign mem.st_value = rkd_r;

    always_comb begin
        case (op_r)
            exe_pkg::OP_DIV, exe_pkg::OP_DIVU: out_result = div.quotient;
            exe_pkg::OP_MOD, exe_pkg::OP_MODU: out_result = div.remainder;
            default:                           out_result = alu_result;
        endcase
    end

    assign out_pc      = pc_r;
    assign out_dest    = dest_r;
    assign out_gr_we   = gr_we_r;
    assign out_is_load = is_load;
    assign out_ale     = valid_r && mem.ale;

    assign fwd_valid   = out_valid && gr_we_r;
    assign fwd_blocked = valid_r && is_load && (out_valid || mem.pending);
    assign fwd_dest    = dest_r;
    assign fwd_result  = out_result;

endmodule

`default_nettype wire

// File: rtl/exe_top.sv
`timescale 1ns/1ps
`default_nettype none

module exe_top #(
    parameter int DIV_BITS_PER_CYCLE = 2
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_valid,
    output logic                        in_allowin,
    input  exe_pkg::exe_op_e            in_op,
    input  logic [exe_pkg::XLEN-1:0]    in_pc,
    input  logic [exe_pkg::XLEN-1:0]    in_rj,
    input  logic [exe_pkg::XLEN-1:0]    in_rkd,
    input  logic [exe_pkg::XLEN-1:0]    in_imm,
    input  logic                        in_src1_is_pc,
    input  logic                        in_src2_is_imm,
    input  logic [exe_pkg::REG_AW-1:0]  in_dest,
    input  logic                        in_gr_we,
    input  logic                        out_allowin,
    output logic                        out_valid,
    output logic [exe_pkg::XLEN-1:0]    out_pc,
    output logic [exe_pkg::XLEN-1:0]    out_result,
    output logic [exe_pkg::REG_AW-1:0]  out_dest,
    output logic                        out_gr_we,
    output logic                        out_is_load,
    output logic                        out_ale,
    output logic                        fwd_valid,
    output logic                        fwd_blocked,
    output logic [exe_pkg::REG_AW-1:0]  fwd_dest,
    output logic [exe_pkg::XLEN-1:0]    fwd_result,
    input  logic                        flush,
    output logic                        data_sram_req,
    output logic                        data_sram_wr,
    output logic [1:0]                  data_sram_size,
    output logic [3:0]                  data_sram_wstrb,
    output logic [exe_pkg::XLEN-1:0]    data_sram_addr,
    output logic [exe_pkg::XLEN-1:0]    data_sram_wdata,
    input  logic                        data_sram_addr_ok,
    input  logic                        data_sram_data_ok
);

    exe_pkg::exe_op_e           alu_op;
    logic [exe_pkg::XLEN-1:0]   alu_src1;
    logic [exe_pkg::XLEN-1:0]   alu_src2;
    logic [exe_pkg::XLEN-1:0]   alu_result;

    div_if div_bus ();
    mem_if mem_bus ();

    exe_ctrl ctrl_i (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_allowin     (in_allowin),
        .in_op          (in_op),
        .in_pc          (in_pc),
        .in_rj          (in_rj),
        .in_rkd         (in_rkd),
        .in_imm         (in_imm),
        .in_src1_is_pc  (in_src1_is_pc),
        .in_src2_is_imm (in_src2_is_imm),
        .in_dest        (in_dest),
        .in_gr_we       (in_gr_we),
        .out_allowin    (out_allowin),
        .out_valid      (out_valid),
        .out_pc         (out_pc),
        .out_result     (out_result),
        .out_dest       (out_dest),
        .out_gr_we      (out_gr_we),
        .out_is_load    (out_is_load),
        .out_ale        (out_ale),
        .fwd_valid      (fwd_valid),
        .fwd_blocked    (fwd_blocked),
        .fwd_dest       (fwd_dest),
        .fwd_result     (fwd_result),
        .flush          (flush),
        .alu_op         (alu_op),
        .alu_src1       (alu_src1),
        .alu_src2       (alu_src2),
        .alu_result     (alu_result),
        .div            (div_bus.ctrl),
        .mem            (mem_bus.ctrl)
    );

    exe_alu alu_i (
        .op     (alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    exe_div #(
        .DIV_BITS_PER_CYCLE (DIV_BITS_PER_CYCLE)
    ) div_i (
        .clk   (clk),
        .reset (reset),
        .div   (div_bus.unit)
    );

    exe_lsu lsu_i (
        .clk               (clk),
        .reset             (reset),
        .mem               (mem_bus.unit),
        .data_sram_req     (data_sram_req),
        .data_sram_wr      (data_sram_wr),
        .data_sram_size    (data_sram_size),
        .data_sram_wstrb   (data_sram_wstrb),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_addr_ok (data_sram_addr_ok),
        .data_sram_data_ok (data_sram_data_ok)
    );

endmodule

`default_nettype wire

// File: bench/exe_tb_tasks.svh
function automatic logic [31:0] alu_model(exe_pkg::exe_op_e op, logic [31:0] a, logic [31:0] b);
    logic [63:0] ps;
    logic [63:0] pu;
    ps = {{32{a[31]}}, a} * {{32{b[31]}}, b};  // low 64 bits of a sign-extended product.
    pu = {32'b0, a} * {32'b0, b};
    case (op)
        exe_pkg::OP_SUB:   return a - b;
        exe_pkg::OP_SLT:   return {31'b0, $signed(a) < $signed(b)};
        exe_pkg::OP_SLTU:  return {31'b0, a < b};
        exe_pkg::OP_AND:   return a & b;
        exe_pkg::OP_OR:    return a | b;
        exe_pkg::OP_XOR:   return a ^ b;
        exe_pkg::OP_NOR:   return ~(a | b);
        exe_pkg::OP_SLL:   return a << b[4:0];
        exe_pkg::OP_SRL:   return a >> b[4:0];
        exe_pkg::OP_SRA:   return 32'($signed(a) >>> b[4:0]);
        exe_pkg::OP_LUI:   return b;
        exe_pkg::OP_MUL:   return ps[31:0];
        exe_pkg::OP_MULH:  return ps[63:32];
        exe_pkg::OP_MULHU: return pu[63:32];
        default:           return a + b;
    endcase
endfunction

function automatic logic [31:0] div_model(exe_pkg::exe_op_e op, logic [31:0] a, logic [31:0] b);
    logic        sgn;
    logic [31:0] q;
    logic [31:0] r;
    sgn = (op == exe_pkg::OP_DIV) || (op == exe_pkg::OP_MOD);
    if (b == 32'h0) begin
        q = 32'hffff_ffff;
        r = a;
    end else if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
        q = a;
        r = 32'h0;
    end else if (sgn) begin
        q = $signed(a) / $signed(b);
        r = $signed(a) % $signed(b);
    end else begin
        q = a / b;
        r = a % b;
    end
    return (op == exe_pkg::OP_DIV || op == exe_pkg::OP_DIVU) ? q : r;
endfunction

task automatic send_instr(exe_pkg::exe_op_e op, logic [31:0] pc, logic [31:0] rj,
                          logic [31:0] rkd, logic [31:0] imm, logic s1, logic s2,
                          logic [4:0] dest, logic we);
    @(negedge clk);
    while (!in_allowin) @(negedge clk);
    @(posedge clk);
    in_valid       <= 1'b1;
    in_op          <= op;
    in_pc          <= pc;
    in_rj          <= rj;
    in_rkd         <= rkd;
    in_imm         <= imm;
    in_src1_is_pc  <= s1;
    in_src2_is_imm <= s2;
    in_dest        <= dest;
    in_gr_we       <= we;
    @(posedge clk);
    in_valid <= 1'b0;
endtask

// counts the cycles from entry until the result is offered downstream.
task automatic wait_out(output int n);
    n = 0;
    do begin
        @(negedge clk);
        n++;
    end while (!out_valid);
endtask

task automatic alu_case(exe_pkg::exe_op_e op);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pc;
    logic [31:0] imm;
    logic [31:0] exp;
    logic        s1;
    logic        s2;
    logic        we;
    logic [4:0]  dest;
    int          n;
    a    = $urandom;
    b    = $urandom;
    pc   = $urandom;
    imm  = $urandom;
    s1   = 1'($urandom_range(1, 0));
    s2   = 1'($urandom_range(1, 0));
    we   = 1'($urandom_range(1, 0));
    dest = 5'($urandom);
    exp  = alu_model(op, s1 ? pc : a, s2 ? imm : b);
    send_instr(op, pc, a, b, imm, s1, s2, dest, we);
    wait_out(n);
    check_eq("alu latency", n, 1);
    check_eq("out_result", out_result, exp);
    check_eq("out_pc", out_pc, pc);
    check_eq("out_dest", 32'(out_dest), 32'(dest));
    check_bit("out_gr_we", out_gr_we, we);
    check_bit("fwd_valid", fwd_valid, we);
    check_eq("fwd_result", fwd_result, exp);
    check_eq("fwd_dest", 32'(fwd_dest), 32'(dest));
endtask

task automatic alu_ops();
    for (int i = 0; i <= 14; i++)
        repeat (4) alu_case(exe_pkg::exe_op_e'(i));
endtask

task automatic divide_ops();
    exe_pkg::exe_op_e op;
    logic [31:0]      a;
    logic [31:0]      b;
    int               n;
    for (int i = 15; i <= 18; i++) begin
        op = exe_pkg::exe_op_e'(i);
        for (int k = 0; k < 6; k++) begin
            a = $urandom;
            b = $urandom >> $urandom_range(31, 0);
            if (k == 4) b = 32'h0;
            if (k == 5) begin
                a = 32'h8000_0000;
                b = 32'hffff_ffff;
            end
            send_instr(op, 32'h0, a, b, 32'h0, 1'b0, 1'b0, 5'd3, 1'b1);
            wait_out(n);
            check_eq("divide latency", n, DIV_LAT);
            check_eq("out_result", out_result, div_model(op, a, b));
            check_eq("fwd_result", fwd_result, div_model(op, a, b));
        end
    end
endtask

task automatic store_case(exe_pkg::exe_op_e op, logic [1:0] off);
    logic [31:0] base;
    logic [31:0] v;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic [1:0]  size;
    base = $urandom & 32'hffff_fffc;
    v    = $urandom;
    case (op)
        exe_pkg::OP_ST_B: begin
            wdata = {4{v[7:0]}};
            strb  = 4'b0001 << off;
            size  = 2'd0;
        end
        exe_pkg::OP_ST_H: begin
            wdata = {2{v[15:0]}};
            strb  = 4'b0011 << off;
            size  = 2'd1;
        end
        default: begin
            wdata = v;
            strb  = 4'b1111;
            size  = 2'd2;
        end
    endcase
    send_instr(op, 32'h0, base, v, 32'(off), 1'b0, 1'b1, 5'd0, 1'b0);
    do begin
        @(negedge clk);
        if (data_sram_req) begin
            check_eq("data_sram_addr", data_sram_addr, base + 32'(off));
            check_eq("data_sram_wdata", data_sram_wdata, wdata);
            check_eq("data_sram_wstrb", 32'(data_sram_wstrb), 32'(strb));
            check_eq("data_sram_size", 32'(data_sram_size), 32'(size));
            check_bit("data_sram_wr", data_sram_wr, 1'b1);
        end
    end while (!out_valid);
    assert (data_sram_req && data_sram_addr_ok) else begin
        err_count++;
        $display("A store left the stage before its address was accepted.");
        $display("Test FAILED");
        $fatal(1);
    end
    check_bit("out_ale", out_ale, 1'b0);
endtask

task automatic aligned_stores();
    for (int off = 0; off < 4; off++)
        store_case(exe_pkg::OP_ST_B, 2'(off));
    store_case(exe_pkg::OP_ST_H, 2'd0);
    store_case(exe_pkg::OP_ST_H, 2'd2);
    store_case(exe_pkg::OP_ST_W, 2'd0);
endtask

task automatic misaligned_accesses();
    exe_pkg::exe_op_e ops [5];
    logic             ld;
    logic             half;
    int               n;
    ops = '{exe_pkg::OP_LD_H, exe_pkg::OP_LD_HU, exe_pkg::OP_ST_H,
            exe_pkg::OP_LD_W, exe_pkg::OP_ST_W};
    for (int i = 0; i < 5; i++) begin
        for (int off = 1; off < 4; off++) begin
            half = (i < 3);
            ld   = (i != 2) && (i != 4);
            if (!(half && off == 2)) begin
                send_instr(ops[i], 32'h0, $urandom & 32'hffff_fffc, $urandom, 32'(off),
                           1'b0, 1'b1, 5'd7, ld);
                wait_out(n);
                check_eq("misaligned latency", n, 1);
                check_bit("out_ale", out_ale, 1'b1);
                check_bit("data_sram_req", data_sram_req, 1'b0);
                check_bit("out_is_load", out_is_load, ld);
                check_bit("fwd_blocked", fwd_blocked, ld);
            end
        end
    end
endtask

task automatic backpressure();
    logic [31:0] a;
    logic [31:0] b;
    int          n;
    a = $urandom;
    b = $urandom;
    @(posedge clk);
    out_allowin <= 1'b0;
    send_instr(exe_pkg::OP_XOR, 32'h0, a, b, 32'h0, 1'b0, 1'b0, 5'd9, 1'b1);
    wait_out(n);
    repeat (4) begin
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b1);
        check_bit("in_allowin", in_allowin, 1'b0);
        check_eq("out_result", out_result, a ^ b);
    end
    @(posedge clk);
    out_allowin <= 1'b1;
    @(negedge clk);
    check_bit("out_valid", out_valid, 1'b1);
    @(negedge clk);
    check_bit("out_valid", out_valid, 1'b0);  // the result went out exactly once.
    @(posedge clk);
    out_allowin <= 1'b0;
    send_instr(exe_pkg::OP_ST_W, 32'h0, $urandom & 32'hffff_fffc, a, 32'h0,
               1'b0, 1'b1, 5'd0, 1'b0);
    repeat (5) begin
        @(negedge clk);
        check_bit("data_sram_req", data_sram_req, 1'b0);
        check_bit("out_valid", out_valid, 1'b0);
    end
    @(posedge clk);
    out_allowin <= 1'b1;
    wait_out(n);
    @(negedge clk);
    check_bit("out_valid", out_valid, 1'b0);
endtask

task automatic flush_pulse();
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
endtask

task automatic flush_cases();
    send_instr(exe_pkg::OP_DIV, 32'h0, $urandom, $urandom | 32'h1, 32'h0,
               1'b0, 1'b0, 5'd4, 1'b1);
    repeat (5) begin
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
    end
    flush_pulse();
    repeat (DIV_LAT + 4) begin
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
    end
    alu_case(exe_pkg::OP_ADD);
    @(posedge clk);
    hold_addr_ok <= 1'b1;
    send_instr(exe_pkg::OP_ST_W, 32'h0, $urandom & 32'hffff_fffc, $urandom, 32'h0,
               1'b0, 1'b1, 5'd0, 1'b0);
    repeat (3) begin
        @(negedge clk);
        check_bit("data_sram_req", data_sram_req, 1'b1);
        check_bit("out_valid", out_valid, 1'b0);
    end
    flush_pulse();
    repeat (8) begin
        @(negedge clk);
        check_bit("data_sram_req", data_sram_req, 1'b0);
        check_bit("out_valid", out_valid, 1'b0);
    end
    @(posedge clk);
    hold_addr_ok <= 1'b0;
    alu_case(exe_pkg::OP_SUB);
endtask

// File: bench/exe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exe_tb;

    localparam int DIV_BITS = 2;
    localparam int DIV_LAT  = 32 / DIV_BITS + 1;
    localparam int NUM_OPS  = 120;

    logic                       clk;
    logic                       reset;
    logic                       in_valid;
    logic                       in_allowin;
    exe_pkg::exe_op_e           in_op;
    logic [31:0]                in_pc;
    logic [31:0]                in_rj;
    logic [31:0]                in_rkd;
    logic [31:0]                in_imm;
    logic                       in_src1_is_pc;
    logic                       in_src2_is_imm;
    logic [4:0]                 in_dest;
    logic                       in_gr_we;
    logic                       out_allowin;
    logic                       out_valid;
    logic [31:0]                out_pc;
    logic [31:0]                out_result;
    logic [4:0]                 out_dest;
    logic                       out_gr_we;
    logic                       out_is_load;
    logic                       out_ale;
    logic                       fwd_valid;
    logic                       fwd_blocked;
    logic [4:0]                 fwd_dest;
    logic [31:0]                fwd_result;
    logic                       flush;
    logic                       data_sram_req;
    logic                       data_sram_wr;
    logic [1:0]                 data_sram_size;
    logic [3:0]                 data_sram_wstrb;
    logic [31:0]                data_sram_addr;
    logic [31:0]                data_sram_wdata;
    logic                       data_sram_addr_ok = 1'b0;
    logic                       data_sram_data_ok = 1'b0;

    logic                       hold_addr_ok;
    logic                       req_s = 1'b0;
    int                         wait_cnt;
    int                         err_count;

    exe_top #(.DIV_BITS_PER_CYCLE(DIV_BITS)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            err_count++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        assert (got === exp) else begin
            err_count++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    // req is sampled mid-cycle so the responder never races the DUT at the edge.
    always @(negedge clk) req_s <= data_sram_req;

    always @(posedge clk) begin
        if (reset) begin
            data_sram_addr_ok <= 1'b0;
            data_sram_data_ok <= 1'b0;
            wait_cnt          <= 0;
        end else begin
            data_sram_data_ok <= data_sram_addr_ok && req_s;  // data follows acceptance.
            if (data_sram_addr_ok && req_s) begin
                data_sram_addr_ok <= 1'b0;
                wait_cnt          <= $urandom_range(3, 0);
            end else if (req_s && !hold_addr_ok) begin
                if (wait_cnt == 0)
                    data_sram_addr_ok <= 1'b1;
                else
                    wait_cnt <= wait_cnt - 1;
            end else begin
                data_sram_addr_ok <= 1'b0;
            end
        end
    end

    `include "exe_tb_tasks.svh"

    initial begin
        #(NUM_OPS * (DIV_LAT + 10) * 4);
        $display("Timeout: the test sequence did not finish in time.");
        $display("Test FAILED");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'h7212707e));
        err_count      = 0;
        hold_addr_ok   <= 1'b0;
        reset          <= 1'b1;
        in_valid       <= 1'b0;
        in_op          <= exe_pkg::OP_ADD;
        in_pc          <= '0;
        in_rj          <= '0;
        in_rkd         <= '0;
        in_imm         <= '0;
        in_src1_is_pc  <= 1'b0;
        in_src2_is_imm <= 1'b0;
        in_dest        <= '0;
        in_gr_we       <= 1'b0;
        out_allowin    <= 1'b1;
        flush          <= 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        alu_ops();
        divide_ops();
        aligned_stores();
        misaligned_accesses();
        backpressure();
        flush_cases();
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
rtl/exe_pkg.sv
rtl/exe_ifs.sv
rtl/exe_alu.sv
rtl/exe_div.sv
rtl/exe_lsu.sv
rtl/exe_ctrl.sv
rtl/exe_top.sv
+incdir+bench
bench/exe_tb.sv

// File: run.sh
#!/bin/sh
# builds the execute stage testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sim.f --top-module exe_tb -o exe_sim \
    && ./obj_dir/exe_sim | grep -q "Test OK" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
